// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= mem_stage.f
VFLAGS    ?= --binary --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_W = 10
) (
    input  logic                          clk,
    input  logic                          en,
    input  logic [lsu_pkg::BYTES-1:0]     wen,
    input  logic [lsu_pkg::XLEN-1:0]      addr,
    input  logic [lsu_pkg::XLEN-1:0]      wdata,
    output logic [lsu_pkg::XLEN-1:0]      rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [lsu_pkg::XLEN-1:0] mem [0:DEPTH-1];
    logic [ADDR_W-1:0]        word_addr;

    // byte offset dropped, upper bits ignored so the space wraps
    assign word_addr = addr[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < lsu_pkg::BYTES; b++) begin
                if (wen[b]) begin
                    mem[word_addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            // old word is returned, the write lands behind it
            rdata <= mem[word_addr];
        end
    end

    a_wen_needs_en: assert property (
        @(posedge clk) (|wen) |-> en
    );

endmodule

// ==== hdl/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,

    input  logic                              ex_ls_ena,
    input  lsu_pkg::ls_sel_t                  ex_ls_sel,
    input  logic [1:0]                        ex_ls_addr_lo,
    input  logic [lsu_pkg::XLEN-1:0]          ex_rt_data,
    input  logic                              ex_w_reg_ena,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    ex_w_reg_dst,
    input  logic                              ex_has_exception,
    input  logic                              is_data_adel,
    input  logic                              is_data_ades,

    output logic                              mem_ls_ena,
    output lsu_pkg::ls_sel_t                  mem_ls_sel,
    output logic [1:0]                        mem_addr_lo,
    output logic [lsu_pkg::XLEN-1:0]          mem_rt_data,
    output logic                              mem_w_reg_ena,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    mem_w_reg_dst,
    output logic                              mem_has_exception
);

    logic has_exception;

    // fault from execute merged with the address errors found here
    assign has_exception = ex_has_exception | is_data_adel | is_data_ades;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ls_ena <= 1'b0;
            mem_w_reg_ena <= 1'b0;
            mem_has_exception <= 1'b0;
        end else if (!stall) begin
            // a faulting instruction leaves no load and no writeback behind
            mem_ls_ena <= ex_ls_ena & ~has_exception;
            mem_w_reg_ena <= ex_w_reg_ena & ~has_exception;
            mem_has_exception <= has_exception;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_ls_sel <= ex_ls_sel;
            mem_addr_lo <= ex_ls_addr_lo;
            mem_rt_data <= ex_rt_data;
            mem_w_reg_dst <= ex_w_reg_dst;
        end
    end

    a_exc_no_side_effect: assert property (
        @(posedge clk) disable iff (rst)
        mem_has_exception |-> (!mem_w_reg_ena && !mem_ls_ena)
    );

    // the load side of lsu sees a frozen instruction while stalled
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> ($stable(mem_ls_ena) &&
                   $stable(mem_ls_sel) &&
                   $stable(mem_addr_lo) &&
                   $stable(mem_rt_data) &&
                   $stable(mem_w_reg_ena) &&
                   $stable(mem_w_reg_dst) &&
                   $stable(mem_has_exception))
    );

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps

module lsu (
    // execute side
    input  logic                          ex_ls_ena,
    input  lsu_pkg::ls_sel_t              ex_ls_sel,
    input  logic [lsu_pkg::XLEN-1:0]      ex_ls_addr,
    input  logic [lsu_pkg::XLEN-1:0]      ex_rt_data,
    input  logic                          ex_has_exception,
    input  logic                          memc_has_exception,
    input  logic                          stall,
    output logic                          is_data_adel,
    output logic                          is_data_ades,

    // memory side, from the EX/MEM register
    input  logic                          mem_has_exception,
    input  logic                          mem_ls_ena,
    input  lsu_pkg::ls_sel_t              mem_ls_sel,
    input  logic [1:0]                    mem_addr_lo,
    input  logic [lsu_pkg::XLEN-1:0]      mem_rt_data,
    output logic [lsu_pkg::XLEN-1:0]      mem_r_data,

    // data RAM
    output logic                          data_ram_en,
    output logic [lsu_pkg::BYTES-1:0]     data_ram_wen,
    output logic [lsu_pkg::XLEN-1:0]      data_ram_addr,
    output logic [lsu_pkg::XLEN-1:0]      data_ram_wdata,
    input  logic [lsu_pkg::XLEN-1:0]      data_ram_rdata
);

    logic [1:0]                  ex_off;
    logic                        is_half_ld;
    logic [lsu_pkg::BYTES-1:0]   wen_raw;
    // ram word with the addressed byte moved down to bit 0
    logic [lsu_pkg::XLEN-1:0]    rd_shift;

    assign ex_off = ex_ls_addr[1:0];

    assign is_half_ld = (ex_ls_sel == lsu_pkg::LS_SEL_LH) |
                        (ex_ls_sel == lsu_pkg::LS_SEL_LHU);

    assign is_data_adel = ex_ls_ena & (
        (is_half_ld & ex_off[0]) |
        ((ex_ls_sel == lsu_pkg::LS_SEL_LW) & (|ex_off))
    );

    assign is_data_ades = ex_ls_ena & (
        ((ex_ls_sel == lsu_pkg::LS_SEL_SH) & ex_off[0]) |
        ((ex_ls_sel == lsu_pkg::LS_SEL_SW) & (|ex_off))
    );

    // any fault here or downstream, or a stall, keeps the access off the ram
    assign data_ram_en = ex_ls_ena &
                         ~is_data_adel &
                         ~is_data_ades &
                         ~ex_has_exception &
                         ~mem_has_exception &
                         ~memc_has_exception &
                         ~stall;

    assign data_ram_addr = ex_ls_addr;

    // store formatting
    always_comb begin
        wen_raw = '0;
        data_ram_wdata = '0;
        case (ex_ls_sel)
            lsu_pkg::LS_SEL_SB: begin
                wen_raw = 4'b0001 << ex_off;
                data_ram_wdata = {4{ex_rt_data[7:0]}};
            end
            lsu_pkg::LS_SEL_SH: begin
                wen_raw = ex_off[1] ? 4'b1100 : 4'b0011;
                data_ram_wdata = {2{ex_rt_data[15:0]}};
            end
            lsu_pkg::LS_SEL_SW: begin
                wen_raw = 4'b1111;
                data_ram_wdata = ex_rt_data;
            end
            // top bytes of rt go to the low end of the word
            lsu_pkg::LS_SEL_SWL: begin
                case (ex_off)
                    2'b00: begin
                        wen_raw = 4'b0001;
                        data_ram_wdata = {24'h0, ex_rt_data[31:24]};
                    end
                    2'b01: begin
                        wen_raw = 4'b0011;
                        data_ram_wdata = {16'h0, ex_rt_data[31:16]};
                    end
                    2'b10: begin
                        wen_raw = 4'b0111;
                        data_ram_wdata = {8'h0, ex_rt_data[31:8]};
                    end
                    default: begin
                        wen_raw = 4'b1111;
                        data_ram_wdata = ex_rt_data;
                    end
                endcase
            end
            // low bytes of rt go to the high end of the word
            lsu_pkg::LS_SEL_SWR: begin
                case (ex_off)
                    2'b00: begin
                        wen_raw = 4'b1111;
                        data_ram_wdata = ex_rt_data;
                    end
                    2'b01: begin
                        wen_raw = 4'b1110;
                        data_ram_wdata = {ex_rt_data[23:0], 8'h0};
                    end
                    2'b10: begin
                        wen_raw = 4'b1100;
                        data_ram_wdata = {ex_rt_data[15:0], 16'h0};
                    end
                    default: begin
                        wen_raw = 4'b1000;
                        data_ram_wdata = {ex_rt_data[7:0], 24'h0};
                    end
                endcase
            end
            default: begin
                wen_raw = '0;
                data_ram_wdata = '0;
            end
        endcase
    end

    assign data_ram_wen = {lsu_pkg::BYTES{data_ram_en}} & wen_raw;

    // load alignment, one cycle after the access
    assign rd_shift = data_ram_rdata >> {mem_addr_lo, 3'b000};

    always_comb begin
        mem_r_data = '0;
        if (mem_ls_ena) begin
            case (mem_ls_sel)
                lsu_pkg::LS_SEL_LB: begin
                    mem_r_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
                end
                lsu_pkg::LS_SEL_LBU: begin
                    mem_r_data = {24'h0, rd_shift[7:0]};
                end
                lsu_pkg::LS_SEL_LH: begin
                    mem_r_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
                end
                lsu_pkg::LS_SEL_LHU: begin
                    mem_r_data = {16'h0, rd_shift[15:0]};
                end
                lsu_pkg::LS_SEL_LW: begin
                    mem_r_data = data_ram_rdata;
                end
                lsu_pkg::LS_SEL_LWL: begin
                    case (mem_addr_lo)
                        2'b00: mem_r_data = {data_ram_rdata[7:0], mem_rt_data[23:0]};
                        2'b01: mem_r_data = {data_ram_rdata[15:0], mem_rt_data[15:0]};
                        2'b10: mem_r_data = {data_ram_rdata[23:0], mem_rt_data[7:0]};
                        default: mem_r_data = data_ram_rdata;
                    endcase
                end
                lsu_pkg::LS_SEL_LWR: begin
                    case (mem_addr_lo)
                        2'b00: mem_r_data = data_ram_rdata;
                        2'b01: mem_r_data = {mem_rt_data[31:24], data_ram_rdata[31:8]};
                        2'b10: mem_r_data = {mem_rt_data[31:16], data_ram_rdata[31:16]};
                        default: mem_r_data = {mem_rt_data[31:8], data_ram_rdata[31:24]};
                    endcase
                end
                // stores return nothing
                default: begin
                    mem_r_data = '0;
                end
            endcase
        end
    end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // data path and address width
    localparam int XLEN = 32;

    // register file index width
    localparam int REG_ADDR_W = 5;

    // bytes per word, also the width of the byte write enable
    localparam int BYTES = XLEN / 8;

    // memory operation select
    // loads sit below 8, stores have bit 3 set
    typedef enum logic [3:0] {
        LS_SEL_LB  = 4'h0,
        LS_SEL_LBU = 4'h1,
        LS_SEL_LH  = 4'h2,
        LS_SEL_LHU = 4'h3,
        LS_SEL_LW  = 4'h4,
        LS_SEL_LWL = 4'h5,
        LS_SEL_LWR = 4'h6,
        LS_SEL_SB  = 4'h8,
        LS_SEL_SH  = 4'h9,
        LS_SEL_SW  = 4'ha,
        LS_SEL_SWL = 4'hb,
        LS_SEL_SWR = 4'hc
    } ls_sel_t;

endpackage

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_W = 10
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,

    input  logic                              ex_ls_ena,
    input  lsu_pkg::ls_sel_t                  ex_ls_sel,
    input  logic [lsu_pkg::XLEN-1:0]          ex_ls_addr,
    input  logic [lsu_pkg::XLEN-1:0]          ex_rt_data,
    input  logic                              ex_w_reg_ena,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    ex_w_reg_dst,
    input  logic                              ex_has_exception,
    input  logic                              memc_has_exception,

    output logic                              is_data_adel,
    output logic                              is_data_ades,
    output logic [lsu_pkg::XLEN-1:0]          mem_r_data,
    output logic                              mem_w_reg_ena,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    mem_w_reg_dst,
    output logic                              mem_has_exception
);

    // EX/MEM register toward the load side
    logic                          mem_ls_ena;
    lsu_pkg::ls_sel_t              mem_ls_sel;
    logic [1:0]                    mem_addr_lo;
    logic [lsu_pkg::XLEN-1:0]      mem_rt_data;

    // ram port
    logic                          data_ram_en;
    logic [lsu_pkg::BYTES-1:0]     data_ram_wen;
    logic [lsu_pkg::XLEN-1:0]      data_ram_addr;
    logic [lsu_pkg::XLEN-1:0]      data_ram_wdata;
    logic [lsu_pkg::XLEN-1:0]      data_ram_rdata;

    lsu u_lsu (
        .ex_ls_ena          (ex_ls_ena),
        .ex_ls_sel          (ex_ls_sel),
        .ex_ls_addr         (ex_ls_addr),
        .ex_rt_data         (ex_rt_data),
        .ex_has_exception   (ex_has_exception),
        .memc_has_exception (memc_has_exception),
        .stall              (stall),
        .is_data_adel       (is_data_adel),
        .is_data_ades       (is_data_ades),
        .mem_has_exception  (mem_has_exception),
        .mem_ls_ena         (mem_ls_ena),
        .mem_ls_sel         (mem_ls_sel),
        .mem_addr_lo        (mem_addr_lo),
        .mem_rt_data        (mem_rt_data),
        .mem_r_data         (mem_r_data),
        .data_ram_en        (data_ram_en),
        .data_ram_wen       (data_ram_wen),
        .data_ram_addr      (data_ram_addr),
        .data_ram_wdata     (data_ram_wdata),
        .data_ram_rdata     (data_ram_rdata)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .ex_ls_ena          (ex_ls_ena),
        .ex_ls_sel          (ex_ls_sel),
        .ex_ls_addr_lo      (ex_ls_addr[1:0]),
        .ex_rt_data         (ex_rt_data),
        .ex_w_reg_ena       (ex_w_reg_ena),
        .ex_w_reg_dst       (ex_w_reg_dst),
        .ex_has_exception   (ex_has_exception),
        .is_data_adel       (is_data_adel),
        .is_data_ades       (is_data_ades),
        .mem_ls_ena         (mem_ls_ena),
        .mem_ls_sel         (mem_ls_sel),
        .mem_addr_lo        (mem_addr_lo),
        .mem_rt_data        (mem_rt_data),
        .mem_w_reg_ena      (mem_w_reg_ena),
        .mem_w_reg_dst      (mem_w_reg_dst),
        .mem_has_exception  (mem_has_exception)
    );

    data_ram #(
        .ADDR_W (ADDR_W)
    ) u_data_ram (
        .clk   (clk),
        .en    (data_ram_en),
        .wen   (data_ram_wen),
        .addr  (data_ram_addr),
        .wdata (data_ram_wdata),
        .rdata (data_ram_rdata)
    );

endmodule

// ==== mem_stage.f ====
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/ex_mem_reg.sv
hdl/data_ram.sv
hdl/mem_stage.sv
tests/mem_stage_tb.sv

// ==== tests/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int ADDR_W = 6;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               stall;
    logic                               ex_ls_ena;
    lsu_pkg::ls_sel_t                   ex_ls_sel;
    logic [lsu_pkg::XLEN-1:0]           ex_ls_addr;
    logic [lsu_pkg::XLEN-1:0]           ex_rt_data;
    logic                               ex_w_reg_ena;
    logic [lsu_pkg::REG_ADDR_W-1:0]     ex_w_reg_dst;
    logic                               ex_has_exception;
    logic                               memc_has_exception;
    logic                               is_data_adel;
    logic                               is_data_ades;
    logic [lsu_pkg::XLEN-1:0]           mem_r_data;
    logic                               mem_w_reg_ena;
    logic [lsu_pkg::REG_ADDR_W-1:0]     mem_w_reg_dst;
    logic                               mem_has_exception;

    // expectation for the op in EX, and for the op in MEM one stage later
    logic        in_adel = 1'b0;
    logic        in_ades = 1'b0;
    logic        in_exc = 1'b0;
    logic        in_wena = 1'b0;
    logic [4:0]  in_dst = '0;
    logic [31:0] in_data = '0;
    logic        chk_on = 1'b0;
    logic        chk_exc = 1'b0;
    logic        chk_wena = 1'b0;
    logic [4:0]  chk_dst = '0;
    logic [31:0] chk_data = '0;

    // byte image of the RAM, 64 words
    logic [7:0]  shadow [0:255];
    logic        prev_fault;
    int          seed;
    string       test_name;

    lsu_pkg::ls_sel_t store_ops [5] = '{lsu_pkg::LS_SEL_SB, lsu_pkg::LS_SEL_SH,
        lsu_pkg::LS_SEL_SW, lsu_pkg::LS_SEL_SWL, lsu_pkg::LS_SEL_SWR};
    lsu_pkg::ls_sel_t load_ops [7] = '{lsu_pkg::LS_SEL_LB, lsu_pkg::LS_SEL_LBU,
        lsu_pkg::LS_SEL_LH, lsu_pkg::LS_SEL_LHU, lsu_pkg::LS_SEL_LW,
        lsu_pkg::LS_SEL_LWL, lsu_pkg::LS_SEL_LWR};
    lsu_pkg::ls_sel_t err_ops [5] = '{lsu_pkg::LS_SEL_LH, lsu_pkg::LS_SEL_LHU,
        lsu_pkg::LS_SEL_LW, lsu_pkg::LS_SEL_SH, lsu_pkg::LS_SEL_SW};

    mem_stage #(
        .ADDR_W (ADDR_W)
    ) uut (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .ex_ls_ena          (ex_ls_ena),
        .ex_ls_sel          (ex_ls_sel),
        .ex_ls_addr         (ex_ls_addr),
        .ex_rt_data         (ex_rt_data),
        .ex_w_reg_ena       (ex_w_reg_ena),
        .ex_w_reg_dst       (ex_w_reg_dst),
        .ex_has_exception   (ex_has_exception),
        .memc_has_exception (memc_has_exception),
        .is_data_adel       (is_data_adel),
        .is_data_ades       (is_data_ades),
        .mem_r_data         (mem_r_data),
        .mem_w_reg_ena      (mem_w_reg_ena),
        .mem_w_reg_dst      (mem_w_reg_dst),
        .mem_has_exception  (mem_has_exception)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s %s expected %h actual %h", test_name, what, exp, act);
        abort_run();
    endtask

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic logic [31:0] rand_addr(input int k);
        logic [31:0] r;
        r = rnd();
        return {r[31:2], k[1:0]};
    endfunction

    // clear the offset bits that the op needs aligned
    function automatic logic [31:0] align_for(input lsu_pkg::ls_sel_t sel, input logic [31:0] a);
        if (sel inside {lsu_pkg::LS_SEL_LH, lsu_pkg::LS_SEL_LHU, lsu_pkg::LS_SEL_SH}) begin
            return {a[31:1], 1'b0};
        end
        if (sel inside {lsu_pkg::LS_SEL_LW, lsu_pkg::LS_SEL_SW}) begin
            return {a[31:2], 2'b00};
        end
        return a;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[7:0] ^ 8'h5a, ~addr[7:0], addr[7:0] + 8'h31, addr[7:0]};
    endfunction

    function automatic logic is_store_op(input lsu_pkg::ls_sel_t sel);
        return sel inside {lsu_pkg::LS_SEL_SB, lsu_pkg::LS_SEL_SH, lsu_pkg::LS_SEL_SW,
                           lsu_pkg::LS_SEL_SWL, lsu_pkg::LS_SEL_SWR};
    endfunction

    function automatic logic load_misaligned(input lsu_pkg::ls_sel_t sel, input logic [31:0] a);
        return ((sel == lsu_pkg::LS_SEL_LH || sel == lsu_pkg::LS_SEL_LHU) && a[0]) ||
               (sel == lsu_pkg::LS_SEL_LW && a[1:0] != 2'b00);
    endfunction

    function automatic logic store_misaligned(input lsu_pkg::ls_sel_t sel, input logic [31:0] a);
        return (sel == lsu_pkg::LS_SEL_SH && a[0]) ||
               (sel == lsu_pkg::LS_SEL_SW && a[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [7:0] base;
        base = {addr[7:2], 2'b00};
        return {shadow[base + 8'd3], shadow[base + 8'd2], shadow[base + 8'd1], shadow[base]};
    endfunction

    // which rt byte lands in byte lane j for a store at offset k, -1 for none
    function automatic int store_src(input lsu_pkg::ls_sel_t sel, input int k, input int j);
        case (sel)
            lsu_pkg::LS_SEL_SB:  return (j == k) ? 0 : -1;
            lsu_pkg::LS_SEL_SH:  return (j / 2 == k / 2) ? j % 2 : -1;
            lsu_pkg::LS_SEL_SW:  return j;
            lsu_pkg::LS_SEL_SWL: return (j <= k) ? 3 - k + j : -1;
            lsu_pkg::LS_SEL_SWR: return (j >= k) ? j - k : -1;
            default:             return -1;
        endcase
    endfunction

    function automatic logic [31:0] load_rule(input lsu_pkg::ls_sel_t sel,
                                              input logic [31:0] addr, input logic [31:0] rt);
        logic [31:0] w;
        logic [31:0] res;
        logic [7:0]  b;
        logic [15:0] h;
        int          k;
        int          j;
        w = word_at(addr);
        k = int'(addr[1:0]);
        b = w[k*8 +: 8];
        h = w[(k / 2)*16 +: 16];
        res = rt;
        case (sel)
            lsu_pkg::LS_SEL_LB:  res = {{24{b[7]}}, b};
            lsu_pkg::LS_SEL_LBU: res = {24'h0, b};
            lsu_pkg::LS_SEL_LH:  res = {{16{h[15]}}, h};
            lsu_pkg::LS_SEL_LHU: res = {16'h0, h};
            lsu_pkg::LS_SEL_LW:  res = w;
            lsu_pkg::LS_SEL_LWL: begin
                for (j = 0; j <= k; j++) begin
                    res[(3 - k + j)*8 +: 8] = w[j*8 +: 8];
                end
            end
            lsu_pkg::LS_SEL_LWR: begin
                for (j = k; j < 4; j++) begin
                    res[(j - k)*8 +: 8] = w[j*8 +: 8];
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic apply_store(input lsu_pkg::ls_sel_t sel, input logic [31:0] addr,
                               input logic [31:0] rt);
        logic [7:0] base;
        int         k;
        int         j;
        int         src;
        base = {addr[7:2], 2'b00};
        k = int'(addr[1:0]);
        for (j = 0; j < 4; j++) begin
            src = store_src(sel, k, j);
            if (src >= 0) begin
                shadow[base + 8'(j)] = rt[src*8 +: 8];
            end
        end
    endtask

    // present one op in EX, optionally held there by stall_n stall cycles
    task automatic drive_op(input lsu_pkg::ls_sel_t sel, input logic ena,
                            input logic [31:0] addr, input logic [31:0] rt,
                            input logic exc, input logic memc, input int stall_n);
        logic        adel;
        logic        ades;
        logic        fault;
        logic        store;
        logic        wena;
        logic [31:0] r;
        int          i;
        adel = ena & load_misaligned(sel, addr);
        ades = ena & store_misaligned(sel, addr);
        fault = exc | adel | ades;
        store = is_store_op(sel);
        wena = ena & ~store;
        r = rnd();
        @(posedge clk);
        ex_ls_ena <= ena;
        ex_ls_sel <= sel;
        ex_ls_addr <= addr;
        ex_rt_data <= rt;
        ex_w_reg_ena <= wena;
        ex_w_reg_dst <= r[4:0];
        ex_has_exception <= exc;
        memc_has_exception <= memc;
        stall <= (stall_n > 0);
        in_adel <= adel;
        in_ades <= ades;
        in_exc <= fault;
        in_wena <= wena & ~fault;
        in_dst <= r[4:0];
        in_data <= (ena && !store && !fault) ? load_rule(sel, addr, rt) : '0;
        // a fault here, in MEM or further down keeps the store out of memory
        if (ena && store && !fault && !prev_fault && !memc) begin
            apply_store(sel, addr, rt);
        end
        prev_fault = fault;
        for (i = 0; i < stall_n; i++) begin
            @(posedge clk);
        end
        if (stall_n > 0) begin
            stall <= 1'b0;
        end
    endtask

    task automatic bubble();
        drive_op(lsu_pkg::LS_SEL_LB, 1'b0, '0, '0, 1'b0, 1'b0, 0);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (mem_w_reg_ena || mem_has_exception) begin
            if (n == 20) begin
                $display("timeout waiting for the memory stage to drain");
                abort_run();
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    // MEM-side expectation moves like the EX/MEM register
    always @(posedge clk) begin
        chk_on <= 1'b1;
        if (rst) begin
            chk_exc <= 1'b0;
            chk_wena <= 1'b0;
            chk_data <= '0;
        end else if (!stall) begin
            chk_exc <= in_exc;
            chk_wena <= in_wena;
            chk_dst <= in_dst;
            chk_data <= in_data;
        end
    end

    a_r_data: assert property (@(posedge clk) chk_on |-> mem_r_data == chk_data)
        else report_mismatch("mem_r_data", $sampled(chk_data), $sampled(mem_r_data));

    a_w_reg_ena: assert property (@(posedge clk) chk_on |-> mem_w_reg_ena == chk_wena)
        else report_mismatch("mem_w_reg_ena", {31'd0, $sampled(chk_wena)},
                             {31'd0, $sampled(mem_w_reg_ena)});

    a_exception: assert property (@(posedge clk) chk_on |-> mem_has_exception == chk_exc)
        else report_mismatch("mem_has_exception", {31'd0, $sampled(chk_exc)},
                             {31'd0, $sampled(mem_has_exception)});

    a_w_reg_dst: assert property (@(posedge clk) (chk_on && chk_wena) |-> mem_w_reg_dst == chk_dst)
        else report_mismatch("mem_w_reg_dst", {27'd0, $sampled(chk_dst)},
                             {27'd0, $sampled(mem_w_reg_dst)});

    a_addr_err: assert property (@(posedge clk) disable iff (rst)
        {is_data_adel, is_data_ades} == {in_adel, in_ades})
        else report_mismatch("adel/ades", {30'd0, $sampled(in_adel), $sampled(in_ades)},
                             {30'd0, $sampled(is_data_adel), $sampled(is_data_ades)});

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(mem_r_data) && $stable(mem_w_reg_dst)))
        else begin
            $display("load result or destination changed while the pipeline was stalled");
            abort_run();
        end

    initial begin
        int          n;
        int          s;
        int          k;
        logic [31:0] a;
        logic [31:0] a2;
        logic [31:0] a3;
        seed = 32'h8e6e_4ead;
        prev_fault = 1'b0;
        test_name = "reset";
        rst <= 1'b1;
        stall <= 1'b0;
        ex_ls_ena <= 1'b0;
        ex_ls_sel <= lsu_pkg::LS_SEL_LB;
        ex_ls_addr <= '0;
        ex_rt_data <= '0;
        ex_w_reg_ena <= 1'b0;
        ex_w_reg_dst <= '0;
        ex_has_exception <= 1'b0;
        memc_has_exception <= 1'b0;
        for (n = 0; n < 16; n++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        test_name = "fill";
        for (n = 0; n < 64; n++) begin
            a = {24'd0, n[5:0], 2'b00};
            drive_op(lsu_pkg::LS_SEL_SW, 1'b1, a, fill_word(a), 1'b0, 1'b0, 0);
        end

        test_name = "stores";
        for (n = 0; n < 2; n++) begin
            for (s = 0; s < 5; s++) begin
                for (k = 0; k < 4; k++) begin
                    a = align_for(store_ops[s], rand_addr(k));
                    drive_op(store_ops[s], 1'b1, a, rnd(), 1'b0, 1'b0, 0);
                    drive_op(lsu_pkg::LS_SEL_LW, 1'b1, {a[31:2], 2'b00}, rnd(), 1'b0, 1'b0, 0);
                end
            end
        end

        test_name = "loads";
        for (n = 0; n < 3; n++) begin
            for (s = 0; s < 7; s++) begin
                for (k = 0; k < 4; k++) begin
                    a = align_for(load_ops[s], rand_addr(k));
                    drive_op(load_ops[s], 1'b1, a, rnd(), 1'b0, 1'b0, 0);
                end
            end
        end

        test_name = "addr_err";
        for (s = 0; s < 5; s++) begin
            for (k = 1; k < 4; k++) begin
                a = rand_addr(k);
                if (load_misaligned(err_ops[s], a) || store_misaligned(err_ops[s], a)) begin
                    drive_op(err_ops[s], 1'b1, a, rnd(), 1'b0, 1'b0, 0);
                    bubble();
                    drive_op(lsu_pkg::LS_SEL_LW, 1'b1, {a[31:2], 2'b00}, rnd(), 1'b0, 1'b0, 0);
                end
            end
        end

        test_name = "suppress";
        for (n = 0; n < 4; n++) begin
            a = rand_addr(0);
            a2 = rand_addr(n);
            a3 = rand_addr(n);
            drive_op(lsu_pkg::LS_SEL_SW, 1'b1, a, rnd(), 1'b1, 1'b0, 0);
            drive_op(lsu_pkg::LS_SEL_SB, 1'b1, a2, rnd(), 1'b0, 1'b0, 0);
            drive_op(lsu_pkg::LS_SEL_SB, 1'b1, a3, rnd(), 1'b0, 1'b1, 0);
            drive_op(lsu_pkg::LS_SEL_LW, 1'b1, a, rnd(), 1'b0, 1'b0, 0);
            drive_op(lsu_pkg::LS_SEL_LW, 1'b1, {a2[31:2], 2'b00}, rnd(), 1'b0, 1'b0, 0);
            drive_op(lsu_pkg::LS_SEL_LW, 1'b1, {a3[31:2], 2'b00}, rnd(), 1'b0, 1'b0, 0);
        end

        test_name = "stall";
        for (n = 0; n < 5; n++) begin
            drive_op(lsu_pkg::LS_SEL_LW, 1'b1, rand_addr(0), rnd(), 1'b0, 1'b0, 0);
            a = align_for(store_ops[n], rand_addr(n % 4));
            drive_op(store_ops[n], 1'b1, a, rnd(), 1'b0, 1'b0, 2 + n);
            drive_op(lsu_pkg::LS_SEL_LW, 1'b1, {a[31:2], 2'b00}, rnd(), 1'b0, 1'b0, 0);
        end

        bubble();
        wait_idle();
        $display("Done: no errors");
        $finish;
    end

endmodule
